// File: rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // widths with a meaning of their own
    typedef logic [63:0] xlen_t;     // register, bus data and bus address word
    typedef logic [31:0] pc_t;       // program counter
    typedef logic [31:0] inst_t;     // raw instruction word
    typedef logic [4:0]  reg_idx_t;  // x0..x31
    typedef logic [11:0] csr_addr_t; // csr space
    typedef logic [3:0]  irq_vec_t;  // external interrupt vector

    // execute stage states
    typedef enum logic [1:0] {
        st_run,       // one instruction per cycle
        st_load_wait, // read data arrives here
        st_flush      // bubble, fetched word dropped
    } exec_state_t;

    // major opcodes, ir[6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3 for loads and stores
    localparam logic [2:0] f3_byte   = 3'b000; // lb / sb
    localparam logic [2:0] f3_double = 3'b011; // ld / sd

    // funct3 for alu and csr ops
    localparam logic [2:0] f3_add    = 3'b000; // addi / add
    localparam logic [2:0] f3_csrrw  = 3'b001;
    localparam logic [2:0] f3_csrrs  = 3'b010;

    // mret is one fixed word
    localparam inst_t inst_mret = 32'h3020_0073;

    // machine csr addresses
    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mie     = 12'h304;
    localparam csr_addr_t csr_mtvec   = 12'h305;
    localparam csr_addr_t csr_mepc    = 12'h341;
    localparam csr_addr_t csr_mcause  = 12'h342;
    localparam csr_addr_t csr_mip     = 12'h344;

    // bit positions inside the csrs
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mie_meie_bit     = 11;
    localparam int mip_meip_bit     = 11; // same slot as meie

    // first fetch address
    localparam pc_t reset_pc = 32'h0000_0000;

endpackage

`default_nettype wire

// File: rtl/rv_reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module rv_reg_file (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::reg_idx_t   rs1_idx,
    input  rv_pkg::reg_idx_t   rs2_idx,
    input  logic               rd_we,
    input  rv_pkg::reg_idx_t   rd_idx,
    input  rv_pkg::xlen_t      rd_data,
    output rv_pkg::xlen_t      rs1_data,
    output rv_pkg::xlen_t      rs2_data
);

    rv_pkg::xlen_t regs [0:31];

    // x0 never gets written, so it reads back as zero
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_idx != 5'd0)) begin
            regs[rd_idx] <= rd_data;
        end
    end

    // async read ports
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

endmodule

`default_nettype wire

// File: rtl/rv_csr_file.sv
`timescale 1ns/10ps
`default_nettype none

module rv_csr_file (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_pkg::irq_vec_t      interrupt_vector,
    input  logic                  csr_we,
    input  logic                  csr_set,
    input  rv_pkg::csr_addr_t     csr_addr,
    input  rv_pkg::xlen_t         csr_wdata,
    input  logic                  trap_enter,
    input  rv_pkg::pc_t           trap_epc,
    input  logic                  trap_return,
    output rv_pkg::xlen_t         csr_rdata,
    output logic                  irq_pending,
    output rv_pkg::xlen_t         mtvec,
    output rv_pkg::xlen_t         mepc
);

    rv_pkg::xlen_t mstatus;
    rv_pkg::xlen_t mie;
    rv_pkg::xlen_t mcause;
    rv_pkg::xlen_t mip;      // read only view
    rv_pkg::xlen_t wr_value; // value a csr write lands with
    logic          meip;

    assign meip = |interrupt_vector; // any nonzero vector is a request

    // take the trap only when both enables are up
    assign irq_pending = mstatus[rv_pkg::mstatus_mie_bit]
                       & mie[rv_pkg::mie_meie_bit]
                       & meip;

    always_comb begin
        mip = '0;
        mip[rv_pkg::mip_meip_bit] = meip;
    end

    // csr read mux, holes read zero
    always_comb begin
        case (csr_addr)
            rv_pkg::csr_mstatus: csr_rdata = mstatus;
            rv_pkg::csr_mie:     csr_rdata = mie;
            rv_pkg::csr_mtvec:   csr_rdata = mtvec;
            rv_pkg::csr_mepc:    csr_rdata = mepc;
            rv_pkg::csr_mcause:  csr_rdata = mcause;
            rv_pkg::csr_mip:     csr_rdata = mip;
            default:             csr_rdata = '0;
        endcase
    end

    // csrrs ors into the old value, csrrw replaces it
    assign wr_value = csr_set ? (csr_rdata | csr_wdata) : csr_wdata;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus <= '0;
            mie     <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (trap_enter) begin
            mepc   <= {32'b0, trap_epc};               // interrupted insn
            mcause <= {1'b1, 59'b0, interrupt_vector}; // interrupt flag + vector
            mstatus[rv_pkg::mstatus_mpie_bit] <= mstatus[rv_pkg::mstatus_mie_bit];
            mstatus[rv_pkg::mstatus_mie_bit]  <= 1'b0; // no nesting
        end else if (trap_return) begin
            // mret puts the old enable back
            mstatus[rv_pkg::mstatus_mie_bit]  <= mstatus[rv_pkg::mstatus_mpie_bit];
            mstatus[rv_pkg::mstatus_mpie_bit] <= 1'b1;
        end else if (csr_we) begin
            case (csr_addr)
                rv_pkg::csr_mstatus: mstatus <= wr_value;
                rv_pkg::csr_mie:     mie     <= wr_value;
                rv_pkg::csr_mtvec:   mtvec   <= wr_value;
                rv_pkg::csr_mepc:    mepc    <= wr_value;
                rv_pkg::csr_mcause:  mcause  <= wr_value;
                default: ; // mip and unknown addresses drop the write
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_exec.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::inst_t       instruction,
    input  rv_pkg::xlen_t       bus_read_data,
    input  rv_pkg::xlen_t       rs1_data,
    input  rv_pkg::xlen_t       rs2_data,
    input  rv_pkg::xlen_t       csr_rdata,
    input  logic                irq_pending,
    input  rv_pkg::xlen_t       mtvec,
    input  rv_pkg::xlen_t       mepc,
    output rv_pkg::pc_t         pc,
    output rv_pkg::inst_t       ir,
    output logic                heartbeat,
    output logic                interrupt_done,
    output rv_pkg::xlen_t       bus_address,
    output rv_pkg::xlen_t       bus_write_data,
    output logic                bus_write_enable,
    output logic                bus_read_enable,
    output rv_pkg::reg_idx_t    rs1_idx,
    output rv_pkg::reg_idx_t    rs2_idx,
    output logic                rd_we,
    output rv_pkg::reg_idx_t    rd_idx,
    output rv_pkg::xlen_t       rd_data,
    output logic                csr_we,
    output logic                csr_set,
    output rv_pkg::csr_addr_t   csr_addr,
    output rv_pkg::xlen_t       csr_wdata,
    output logic                trap_enter,
    output rv_pkg::pc_t         trap_epc,
    output logic                trap_return
);

    rv_pkg::exec_state_t state;
    rv_pkg::exec_state_t state_next;
    rv_pkg::pc_t         pc_next;

    // instruction fields
    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    rv_pkg::xlen_t imm_i;
    rv_pkg::xlen_t imm_s;
    rv_pkg::xlen_t imm_u;
    rv_pkg::xlen_t load_ext;

    // decode flags
    logic is_load;
    logic is_store;
    logic is_csr;
    logic is_mret;
    logic take_irq; // trap instead of executing ir
    logic exec;     // ir really executes this cycle
    logic stall;    // hold pc and ir

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};

    // only lb/ld and sb/sd, other widths fall through as no-ops
    assign is_load  = (opcode == rv_pkg::op_load)
                    && (funct3 == rv_pkg::f3_byte || funct3 == rv_pkg::f3_double);
    assign is_store = (opcode == rv_pkg::op_store)
                    && (funct3 == rv_pkg::f3_byte || funct3 == rv_pkg::f3_double);
    assign is_csr   = (opcode == rv_pkg::op_system)
                    && (funct3 == rv_pkg::f3_csrrw || funct3 == rv_pkg::f3_csrrs);
    assign is_mret  = (ir == rv_pkg::inst_mret);

    // a load is never interrupted halfway
    assign take_irq = (state == rv_pkg::st_run) && irq_pending && !is_load;
    assign exec     = (state == rv_pkg::st_run) && !take_irq;
    assign stall    = exec && is_load;

    assign rs1_idx = ir[19:15];
    assign rs2_idx = ir[24:20];
    assign rd_idx  = ir[11:7];

    // bus, issued in the same cycle the insn executes
    assign bus_read_enable  = exec && is_load;
    assign bus_write_enable = exec && is_store;
    assign bus_address      = rs1_data + (is_store ? imm_s : imm_i);
    assign bus_write_data   = (funct3 == rv_pkg::f3_byte) ? {56'b0, rs2_data[7:0]}
                                                          : rs2_data;

    // lb sign extends, ld takes the full word
    assign load_ext = (funct3 == rv_pkg::f3_byte)
                    ? {{56{bus_read_data[7]}}, bus_read_data[7:0]}
                    : bus_read_data;

    // csr access, csrrs with x0 ors in zero so nothing changes
    assign csr_we    = exec && is_csr;
    assign csr_set   = (funct3 == rv_pkg::f3_csrrs);
    assign csr_addr  = ir[31:20];
    assign csr_wdata = rs1_data;

    // trap handshake with the csr block
    assign trap_enter  = take_irq;
    assign trap_epc    = pc - 32'd4; // ir came from pc-4
    assign trap_return = exec && is_mret;

    // register writeback
    always_comb begin
        rd_we   = 1'b0;
        rd_data = '0;
        if (state == rv_pkg::st_load_wait) begin
            rd_we   = 1'b1; // ir still holds the load
            rd_data = load_ext;
        end else if (exec) begin
            case (opcode)
                rv_pkg::op_lui: begin
                    rd_we   = 1'b1;
                    rd_data = imm_u;
                end
                rv_pkg::op_op_imm: begin
                    rd_we   = (funct3 == rv_pkg::f3_add); // addi only
                    rd_data = rs1_data + imm_i;
                end
                rv_pkg::op_op: begin
                    rd_we   = (funct3 == rv_pkg::f3_add) && (funct7 == 7'b0);
                    rd_data = rs1_data + rs2_data;
                end
                rv_pkg::op_system: begin
                    rd_we   = is_csr; // old csr value to rd
                    rd_data = csr_rdata;
                end
                default: ;
            endcase
        end
    end

    // next pc and state
    always_comb begin
        pc_next    = pc + 32'd4;
        state_next = state;
        case (state)
            rv_pkg::st_run: begin
                if (take_irq) begin
                    pc_next    = {mtvec[31:2], 2'b00}; // direct mode only
                    state_next = rv_pkg::st_flush;
                end else if (is_load) begin
                    pc_next    = pc;
                    state_next = rv_pkg::st_load_wait;
                end else if (is_mret) begin
                    pc_next    = mepc[31:0];
                    state_next = rv_pkg::st_flush;
                end
            end
            rv_pkg::st_load_wait: begin
                pc_next    = pc; // word at pc is refetched in the bubble
                state_next = rv_pkg::st_flush;
            end
            rv_pkg::st_flush: state_next = rv_pkg::st_run;
            default:          state_next = rv_pkg::st_run;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc             <= rv_pkg::reset_pc;
            ir             <= '0; // executes as a no-op
            state          <= rv_pkg::st_run;
            heartbeat      <= 1'b0;
            interrupt_done <= 1'b0;
        end else begin
            heartbeat      <= ~heartbeat;
            interrupt_done <= trap_return; // one cycle pulse after mret
            pc             <= pc_next;
            state          <= state_next;
            if (!stall) begin
                ir <= instruction; // fetch
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/riscv64.sv
`timescale 1ns/10ps
`default_nettype none

module riscv64 (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::inst_t      instruction,
    output rv_pkg::pc_t        pc,
    output rv_pkg::inst_t      ir,
    output logic               heartbeat,
    input  rv_pkg::irq_vec_t   interrupt_vector,
    output logic               interrupt_done,
    output rv_pkg::xlen_t      bus_address,
    output rv_pkg::xlen_t      bus_write_data,
    output logic               bus_write_enable,
    output logic               bus_read_enable,
    input  rv_pkg::xlen_t      bus_read_data
);

    // register file port
    rv_pkg::reg_idx_t  rs1_idx;
    rv_pkg::reg_idx_t  rs2_idx;
    rv_pkg::reg_idx_t  rd_idx;
    rv_pkg::xlen_t     rs1_data;
    rv_pkg::xlen_t     rs2_data;
    rv_pkg::xlen_t     rd_data;
    logic              rd_we;

    // csr port and trap handshake
    logic              csr_we;
    logic              csr_set;
    rv_pkg::csr_addr_t csr_addr;
    rv_pkg::xlen_t     csr_wdata;
    rv_pkg::xlen_t     csr_rdata;
    logic              irq_pending;
    logic              trap_enter;
    rv_pkg::pc_t       trap_epc;
    logic              trap_return;
    rv_pkg::xlen_t     mtvec;
    rv_pkg::xlen_t     mepc;

    rv_exec rv_exec_i (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .bus_read_data    (bus_read_data),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .csr_rdata        (csr_rdata),
        .irq_pending      (irq_pending),
        .mtvec            (mtvec),
        .mepc             (mepc),
        .pc               (pc),
        .ir               (ir),
        .heartbeat        (heartbeat),
        .interrupt_done   (interrupt_done),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .rs1_idx          (rs1_idx),
        .rs2_idx          (rs2_idx),
        .rd_we            (rd_we),
        .rd_idx           (rd_idx),
        .rd_data          (rd_data),
        .csr_we           (csr_we),
        .csr_set          (csr_set),
        .csr_addr         (csr_addr),
        .csr_wdata        (csr_wdata),
        .trap_enter       (trap_enter),
        .trap_epc         (trap_epc),
        .trap_return      (trap_return)
    );

    rv_reg_file rv_reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rd_we    (rd_we),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_csr_file rv_csr_file_i (
        .clk              (clk),
        .reset            (reset),
        .interrupt_vector (interrupt_vector),
        .csr_we           (csr_we),
        .csr_set          (csr_set),
        .csr_addr         (csr_addr),
        .csr_wdata        (csr_wdata),
        .trap_enter       (trap_enter),
        .trap_epc         (trap_epc),
        .trap_return      (trap_return),
        .csr_rdata        (csr_rdata),
        .irq_pending      (irq_pending),
        .mtvec            (mtvec),
        .mepc             (mepc)
    );

endmodule

`default_nettype wire

// File: tb/riscv64_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module riscv64_assertions (
    input logic          clk,
    input logic          reset,
    input rv_pkg::pc_t   pc,
    input logic          heartbeat,
    input logic          interrupt_done,
    input logic          bus_read_enable,
    input logic          bus_write_enable,
    input logic          trap_enter,
    input logic          trap_return,
    input rv_pkg::xlen_t mtvec,
    input rv_pkg::xlen_t mepc
);

    int fail_count = 0; // summed into the testbench error count

    // one edge into reset the core is quiet
    reset_state: assert property (@(posedge clk)
        !reset |=> (pc == rv_pkg::reset_pc) && !bus_read_enable && !bus_write_enable
                   && !interrupt_done && !trap_enter && !trap_return)
        else begin
            $error("core is not in its reset state");
            fail_count++;
        end

    heartbeat_toggle: assert property (@(posedge clk) disable iff (!reset)
        1'b1 |=> heartbeat != $past(heartbeat))
        else begin
            $error("heartbeat did not toggle");
            fail_count++;
        end

    // the load holds pc while its read is out
    read_holds_pc: assert property (@(posedge clk) disable iff (!reset)
        bus_read_enable |=> pc == $past(pc))
        else begin
            $error("pc moved while a bus read was issued");
            fail_count++;
        end

    read_write_apart: assert property (@(posedge clk) disable iff (!reset)
        !(bus_read_enable && bus_write_enable))
        else begin
            $error("bus read and bus write in the same cycle");
            fail_count++;
        end

    // sequential flow, load wait cycle excluded through $past
    pc_step: assert property (@(posedge clk) disable iff (!reset)
        (!bus_read_enable && !$past(bus_read_enable) && !trap_enter && !trap_return)
        |=> pc == $past(pc) + 32'd4)
        else begin
            $error("pc did not advance by 4");
            fail_count++;
        end

    trap_to_mtvec: assert property (@(posedge clk) disable iff (!reset)
        trap_enter |=> pc == $past(mtvec[31:0]))
        else begin
            $error("trap did not jump to mtvec");
            fail_count++;
        end

    mret_to_mepc: assert property (@(posedge clk) disable iff (!reset)
        trap_return |=> interrupt_done && (pc == $past(mepc[31:0])))
        else begin
            $error("mret did not return to mepc with interrupt_done");
            fail_count++;
        end

endmodule

bind riscv64 riscv64_assertions riscv64_assertions_i (
    .clk              (clk),
    .reset            (reset),
    .pc               (pc),
    .heartbeat        (heartbeat),
    .interrupt_done   (interrupt_done),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable),
    .trap_enter       (trap_enter),
    .trap_return      (trap_return),
    .mtvec            (mtvec),
    .mepc             (mepc)
);

`default_nettype wire

// File: tb/riscv64_tb.sv
`timescale 1ns/10ps
`default_nettype none

module riscv64_tb;

    localparam rv_pkg::inst_t    nop        = 32'h0000_0013; // addi x0, x0, 0
    localparam int               wait_limit = 200;           // cycles per wait loop
    localparam logic [19:0]      lui_imm    = 20'h12345;
    localparam logic [11:0]      addi_imm_a = 12'h678;
    localparam logic [11:0]      addi_imm_b = 12'hff8;       // -8
    localparam rv_pkg::xlen_t    store_base = 64'h80;        // x5 holds this
    localparam rv_pkg::pc_t      handler_pc = 32'h200;       // written to mtvec
    localparam rv_pkg::pc_t      irq_pc     = 32'd72;        // word in ir when the vector rises
    localparam rv_pkg::irq_vec_t vec_taken  = 4'h9;
    localparam rv_pkg::irq_vec_t vec_masked = 4'h5;

    logic             clk;
    logic             reset;
    rv_pkg::inst_t    instruction;
    rv_pkg::pc_t      pc;
    rv_pkg::inst_t    ir;
    logic             heartbeat;
    rv_pkg::irq_vec_t interrupt_vector;
    logic             interrupt_done;
    rv_pkg::xlen_t    bus_address;
    rv_pkg::xlen_t    bus_write_data;
    logic             bus_write_enable;
    logic             bus_read_enable;
    rv_pkg::xlen_t    bus_read_data;

    rv_pkg::inst_t program_mem [0:255]; // word index pc[9:2]
    logic [7:0]    bus_mem [0:255];
    logic [31:0]   lfsr;
    logic          read_pending;        // read seen mid cycle, answered after the edge
    logic [7:0]    read_addr;
    rv_pkg::xlen_t store_addr_q [$];
    rv_pkg::xlen_t store_data_q [$];
    int            errors;
    int            checks;
    int            tests;
    int            errors_at_start;
    int            n;
    int            total;
    rv_pkg::pc_t   last_pc;
    logic          last_hb;
    logic [7:0]    byte_val;
    rv_pkg::xlen_t exp_sum;

    riscv64 riscv64_i (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .ir               (ir),
        .heartbeat        (heartbeat),
        .interrupt_vector (interrupt_vector),
        .interrupt_done   (interrupt_done),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data)
    );

    always #2 clk = ~clk; // 4 ns period

    // galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic rv_pkg::inst_t u_type(input logic [19:0] imm, input rv_pkg::reg_idx_t rd);
        return {imm, rd, rv_pkg::op_lui};
    endfunction

    function automatic rv_pkg::inst_t i_type(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                             input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
                                             input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::inst_t s_type(input logic [11:0] imm, input rv_pkg::reg_idx_t rs2,
                                             input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::op_store};
    endfunction

    function automatic rv_pkg::inst_t r_add(input rv_pkg::reg_idx_t rd, input rv_pkg::reg_idx_t rs1,
                                            input rv_pkg::reg_idx_t rs2);
        return {7'b0, rs2, rs1, rv_pkg::f3_add, rd, rv_pkg::op_op};
    endfunction

    // eight bytes from a, little endian, wrapping at 256
    function automatic rv_pkg::xlen_t read_word(input logic [7:0] a);
        rv_pkg::xlen_t w;
        for (int k = 0; k < 8; k++) begin
            w[8*k +: 8] = bus_mem[(a + k) % 256];
        end
        return w;
    endfunction

    function automatic int error_total();
        return errors + riscv64_i.riscv64_assertions_i.fail_count;
    endfunction

    task automatic fill_bus_mem();
        lfsr = 32'd99319;
        for (int a = 0; a < 256; a++) begin
            for (int b = 0; b < 8; b++) begin
                bus_mem[a][b] = lfsr[0]; // one step per bit
                lfsr = lfsr_next(lfsr);
            end
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            program_mem[i] = nop;
        end
        program_mem[0]   = u_type(lui_imm, 5'd1);
        program_mem[1]   = i_type(addi_imm_a, 5'd1, rv_pkg::f3_add, 5'd2, rv_pkg::op_op_imm);
        program_mem[2]   = i_type(addi_imm_b, 5'd0, rv_pkg::f3_add, 5'd3, rv_pkg::op_op_imm);
        program_mem[3]   = r_add(5'd4, 5'd2, 5'd3);
        program_mem[4]   = i_type(store_base[11:0], 5'd0, rv_pkg::f3_add, 5'd5, rv_pkg::op_op_imm);
        program_mem[5]   = s_type(12'h008, 5'd4, 5'd5, rv_pkg::f3_double);     // sd x4
        program_mem[6]   = i_type(12'h010, 5'd0, rv_pkg::f3_double, 5'd6, rv_pkg::op_load);
        program_mem[7]   = s_type(12'h020, 5'd6, 5'd5, rv_pkg::f3_double);
        program_mem[8]   = i_type(12'h013, 5'd0, rv_pkg::f3_byte, 5'd7, rv_pkg::op_load);
        program_mem[9]   = s_type(12'h028, 5'd7, 5'd5, rv_pkg::f3_double);
        program_mem[10]  = i_type(handler_pc[11:0], 5'd0, rv_pkg::f3_add, 5'd8, rv_pkg::op_op_imm);
        program_mem[11]  = i_type(rv_pkg::csr_mtvec, 5'd8, rv_pkg::f3_csrrw, 5'd0,
                                  rv_pkg::op_system);
        program_mem[12]  = u_type(20'h00001, 5'd9);                             // x9 = 0x1000
        program_mem[13]  = i_type(12'h800, 5'd9, rv_pkg::f3_add, 5'd9, rv_pkg::op_op_imm);
        program_mem[14]  = i_type(rv_pkg::csr_mie, 5'd9, rv_pkg::f3_csrrs, 5'd0,
                                  rv_pkg::op_system);
        program_mem[15]  = i_type(12'h008, 5'd0, rv_pkg::f3_add, 5'd10, rv_pkg::op_op_imm);
        program_mem[16]  = i_type(rv_pkg::csr_mstatus, 5'd10, rv_pkg::f3_csrrs, 5'd0,
                                  rv_pkg::op_system);                           // mie on
        program_mem[24]  = i_type(rv_pkg::csr_mstatus, 5'd0, rv_pkg::f3_csrrw, 5'd0,
                                  rv_pkg::op_system);                           // mie off again
        // handler at mtvec
        program_mem[128] = i_type(rv_pkg::csr_mcause, 5'd0, rv_pkg::f3_csrrs, 5'd11,
                                  rv_pkg::op_system);
        program_mem[129] = s_type(12'h030, 5'd11, 5'd5, rv_pkg::f3_double);
        program_mem[130] = rv_pkg::inst_mret;
    endtask

    task automatic check_value(input string what, input rv_pkg::xlen_t got,
                               input rv_pkg::xlen_t exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // next write seen on the bus against the expected one
    task automatic expect_store(input string what, input rv_pkg::xlen_t addr,
                                input rv_pkg::xlen_t data);
        int i;
        i = 0;
        while (store_addr_q.size() == 0) begin
            if (i == wait_limit) give_up({what, " store"});
            @(negedge clk);
            i++;
        end
        check_value({what, " address"}, store_addr_q.pop_front(), addr);
        check_value({what, " data"}, store_data_q.pop_front(), data);
    endtask

    task automatic wait_pc(input rv_pkg::pc_t target);
        int i;
        i = 0;
        while (pc !== target) begin
            if (i == wait_limit) give_up($sformatf("pc reaching %h", target));
            @(negedge clk);
            i++;
        end
    endtask

    task automatic wait_done();
        int i;
        i = 0;
        while (interrupt_done !== 1'b1) begin
            if (i == wait_limit) give_up("interrupt_done pulse");
            @(negedge clk);
            i++;
        end
    endtask

    task automatic drive_vector(input rv_pkg::irq_vec_t v);
        @(posedge clk);
        #1;
        interrupt_vector = v;
    endtask

    task automatic end_test(input string name);
        int now;
        now = error_total();
        tests++;
        if (now == errors_at_start) $display("test %-10s ok", name);
        else $display("test %-10s %0d errors", name, now - errors_at_start);
        errors_at_start = now;
    endtask

    // fetch and read data go out 1 ns after the edge
    always @(posedge clk) begin
        #1;
        instruction = program_mem[pc[9:2]];
        if (read_pending) begin
            bus_read_data = read_word(read_addr);
        end
    end

    // bus requests sampled mid cycle
    always @(negedge clk) begin
        read_pending = bus_read_enable;
        read_addr    = bus_address[7:0];
        if (bus_write_enable) begin
            store_addr_q.push_back(bus_address);
            store_data_q.push_back(bus_write_data);
        end
    end

    initial begin
        clk              = 1'b0;
        reset            = 1'b0;
        instruction      = nop;
        interrupt_vector = '0;
        bus_read_data    = '0;
        read_pending     = 1'b0;
        read_addr        = '0;
        errors           = 0;
        checks           = 0;
        tests            = 0;
        errors_at_start  = 0;
        fill_bus_mem();
        load_program();

        // reset held for 5 edges
        repeat (5) begin
            @(posedge clk);
            #1;
            check_value("pc in reset", pc, rv_pkg::reset_pc);
            check_value("ir in reset", ir, 0);
            check_value("read enable in reset", bus_read_enable, 0);
            check_value("write enable in reset", bus_write_enable, 0);
            check_value("interrupt_done in reset", interrupt_done, 0);
        end
        reset = 1'b1;
        @(negedge clk);
        last_hb = heartbeat;
        n = 0;
        repeat (4) begin
            @(negedge clk);
            check_value("heartbeat", heartbeat, !last_hb);
            check_value("ir fetch", ir, program_mem[n]); // one word per edge, no loads yet
            last_hb = heartbeat;
            n++;
        end
        end_test("reset");

        // lui + addi + addi + add, sign extended immediates
        exp_sum = {{32{lui_imm[19]}}, lui_imm, 12'h000}
                + {{52{addi_imm_a[11]}}, addi_imm_a}
                + {{52{addi_imm_b[11]}}, addi_imm_b};
        expect_store("add sum", store_base + 64'h08, exp_sum);
        end_test("arith");

        expect_store("ld word", store_base + 64'h20, read_word(8'h10));
        byte_val = bus_mem[8'h13];
        expect_store("lb byte", store_base + 64'h28, {{56{byte_val[7]}}, byte_val});
        end_test("load");

        // raise the vector once mie and mstatus.mie are set
        wait_pc(irq_pc);
        drive_vector(vec_taken); // ir now holds the word fetched at irq_pc
        n = 0;
        while (pc !== handler_pc) begin
            if (n == wait_limit) give_up("trap to mtvec");
            @(negedge clk);
            n++;
        end
        drive_vector('0);
        expect_store("mcause", store_base + 64'h30, {1'b1, 59'b0, vec_taken});
        wait_done();
        check_value("pc after mret", pc, irq_pc);
        end_test("irq_taken");

        // mstatus.mie cleared at word 24
        wait_pc(32'd120);
        drive_vector(vec_masked);
        @(negedge clk);
        last_pc = pc;
        repeat (12) begin
            @(negedge clk);
            check_value("pc while masked", pc, last_pc + 32'd4);
            last_pc = pc;
        end
        drive_vector('0);
        repeat (4) @(negedge clk); // let the bound checks settle
        end_test("irq_masked");

        total = error_total();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, total);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
rtl/rv_pkg.sv
rtl/rv_reg_file.sv
rtl/rv_csr_file.sv
rtl/rv_exec.sv
rtl/riscv64.sv
tb/riscv64_assertions.sv
tb/riscv64_tb.sv

// File: Bender.yml
package:
  name: riscv64

sources:
  - files:
      - rtl/rv_pkg.sv
      - rtl/rv_reg_file.sv
      - rtl/rv_csr_file.sv
      - rtl/rv_exec.sv
      - rtl/riscv64.sv
  - target: test
    files:
      - tb/riscv64_assertions.sv
      - tb/riscv64_tb.sv
